// ==== bench/rvPipeline_assert.sv ====
`timescale 1ns/100ps

module rvPipelineAssert (
    input logic        clk,
    input logic        reset,
    input logic        memWrite,
    input logic [31:0] pc,
    input logic        stallF,
    input logic        pcSrc
);

    int failures = 0;

    memWriteKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(memWrite))
        else begin
            $error("memWrite is unknown");
            failures++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc %h is not word aligned", pc);
            failures++;
        end

    // A load in execute never redirects
    noStallOnRedirect: assert property (@(posedge clk) disable iff (reset) !(stallF && pcSrc))
        else begin
            $error("stallF and pcSrc high together");
            failures++;
        end

endmodule

bind rvPipeline rvPipelineAssert u_assert (
    .clk      (clk),
    .reset    (reset),
    .memWrite (memWrite),
    .pc       (pc),
    .stallF   (stallF),
    .pcSrc    (pcSrc)
);

// ==== bench/rvModel.svh ====
// ============================================================================
// Random program builder and instruction-level reference model
// ============================================================================

localparam int romWords  = 128;
localparam int progInstr = 40;

logic [31:0] rngState;
logic [31:0] rom [romWords];
logic [31:0] modelMem [64];    // Persists across tests like the DUT memory
logic [31:0] expAdr [$];
logic [31:0] expData [$];

function automatic logic [31:0] nextRand();
    logic [31:0] s;
    s = rngState;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rngState = s;
    return s;
endfunction

// RV32I instruction formats
function automatic logic [31:0] encR(input logic sub, input logic [2:0] f3,
                                     input logic [4:0] rd, rs1, rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                     input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};   // Base is x0
endfunction

function automatic logic [31:0] encB(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Kind 0 clears memory, 1 is ALU heavy, 2 is load-use heavy, 3 mixes beq and jal
task automatic buildProgram(input int kind);
    int          n;
    int          cls;        // 0 alu, 1 load, 2 store, 3 beq, 4 jal
    logic [31:0] r;
    logic [31:0] v;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  lastRd;
    logic        afterLoad;
    logic [2:0]  f3;
    n         = 0;
    lastRd    = 5'd1;
    afterLoad = 1'b0;
    foreach (rom[i])
        rom[i] = '0;
    if (kind == 0) begin
        for (int k = 0; k < 64; k++) begin
            rom[n] = encS(5'd0, 12'(4 * k));
            n++;
        end
    end else begin
        for (int i = 0; i < progInstr; i++) begin
            r  = nextRand();
            v  = nextRand();
            ra = r[15] ? lastRd : r[9:5];     // Lean on the last result
            rb = r[16] ? lastRd : r[14:10];
            case (kind)
                1:       cls = (r[31:28] < 13) ? 0 : 2;
                2:       cls = (r[31:28] < 7) ? 1 : (r[31:28] < 14) ? 0 : 2;
                default: cls = (r[31:28] < 5) ? 3 : (r[31:28] < 8) ? 4 :
                               (r[31:28] < 14) ? 0 : 2;
            endcase
            if (afterLoad) begin
                cls = 0;
                ra  = lastRd;                 // Consume the load right away
            end
            afterLoad = (cls == 1);
            case (r[26:25])
                2'd0:    f3 = 3'b000;
                2'd1:    f3 = 3'b010;         // slt
                2'd2:    f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            case (cls)
                0: rom[n] = r[27] ? encR(r[24] && f3 == 3'b000, f3, r[4:0], ra, rb)
                                  : encI(7'b0010011, f3, r[4:0], ra, v[11:0]);
                1: rom[n] = encI(7'b0000011, 3'b010, r[4:0], 5'd0, {4'b0, r[21:16], 2'b00});
                2: rom[n] = encS(rb, {4'b0, r[21:16], 2'b00});
                3: rom[n] = encB(ra, r[20] ? ra : rb, 13'(4 * (2 + r[19:18])));
                default: rom[n] = encJ(r[4:0], 21'(4 * (1 + r[19:18])));
            endcase
            if (cls == 0 || cls == 1 || cls == 4)
                lastRd = r[4:0];
            n++;
        end
        for (int k = 1; k < 32; k++) begin   // Dump x1 to x31
            rom[n] = encS(5'(k), 12'(4 * (k - 1)));
            n++;
        end
    end
    rom[n] = encJ(5'd0, 21'd0);
endtask

task automatic runModel();
    logic [31:0] x [32];
    logic [31:0] mpc;
    logic [31:0] nextPc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ad;
    logic [31:0] immI;
    logic [31:0] immJ;
    logic        done;
    int          steps;
    foreach (x[i])
        x[i] = '0;
    mpc   = '0;
    done  = 1'b0;
    steps = 0;
    expAdr.delete();
    expData.delete();
    while (!done && steps < 4 * romWords) begin
        ins    = rom[mpc[8:2]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        a      = x[ins[19:15]];
        b      = (ins[6:0] == 7'b0110011) ? x[ins[24:20]] : immI;
        nextPc = mpc + 32'd4;
        case (ins[14:12])
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: res = (ins[6:0] == 7'b0110011 && ins[30]) ? a - b : a + b;
        endcase
        case (ins[6:0])
            7'b0110011, 7'b0010011: x[ins[11:7]] = res;
            7'b0000011: begin
                ad = a + immI;
                x[ins[11:7]] = modelMem[ad[7:2]];
            end
            7'b0100011: begin
                ad = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                modelMem[ad[7:2]] = x[ins[24:20]];
                expAdr.push_back(ad);
                expData.push_back(x[ins[24:20]]);
            end
            7'b1100011: begin
                if (a == x[ins[24:20]])
                    nextPc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b1101111: begin
                done         = (immJ == '0);   // Self-loop ends the program
                x[ins[11:7]] = nextPc;
                nextPc       = mpc + immJ;
            end
            default: ;
        endcase
        x[0] = '0;
        mpc  = nextPc;
        steps++;
    end
endtask

// ==== bench/rvSystemTb.sv ====
`timescale 1ns/100ps

module rvSystemTb;

    localparam int rounds     = 4;
    localparam int numTests   = 1 + 3 * rounds;
    localparam int testCycles = 40 * 4 + 100;
    localparam int tailCycles = 20;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] dataAdr;
    logic [31:0] writeData;
    logic        memWrite;

    int testErrors;
    int passCount;
    int failCount;
    int storeIdx;
    int curTest;

    `include "rvModel.svh"

    rvSystem u_dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .pc        (pc),
        .dataAdr   (dataAdr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    assign instr = rom[pc[8:2]];   // Combinational instruction ROM

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // Store monitor
    // ========================================================================
    always @(posedge clk) begin
        if (!reset && memWrite) begin
            if (storeIdx >= expAdr.size()) begin
                $display("Extra store at %0t in test %0d to address %h", $time, curTest,
                         dataAdr);
                testErrors++;
            end else begin
                if (dataAdr !== expAdr[storeIdx]) begin
                    $display("ERR %0t dataAdr: got %h, expected %h", $time, dataAdr,
                             expAdr[storeIdx]);
                    testErrors++;
                end
                if (writeData !== expData[storeIdx]) begin
                    $display("ERR %0t writeData: got %h, expected %h", $time, writeData,
                             expData[storeIdx]);
                    testErrors++;
                end
            end
            storeIdx++;
        end
    end

    task automatic runTest(input int kind, input string name);
        curTest++;
        testErrors = 0;
        reset      = 1'b1;
        buildProgram(kind);
        runModel();
        storeIdx = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (pc !== 32'd0) begin
            $display("ERR %0t pc: got %h, expected %h", $time, pc, 32'd0);
            testErrors++;
        end
        for (int i = 0; i < 3; i++) begin    // No store can reach memory yet
            if (memWrite !== 1'b0) begin
                $display("ERR %0t memWrite: got %b, expected %b", $time, memWrite, 1'b0);
                testErrors++;
            end
            @(negedge clk);
        end
        while (storeIdx < expAdr.size())
            @(negedge clk);
        repeat (tailCycles) @(negedge clk); // Self-loop must stay quiet
        if (storeIdx != expAdr.size()) begin
            $display("Store count wrong in test %0d, saw %0d but expected %0d", curTest,
                     storeIdx, expAdr.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            passCount++;
            $display("Test %0d %s: pass, %0d stores", curTest, name, storeIdx);
        end else begin
            failCount++;
            $display("Test %0d %s: FAIL, %0d errors", curTest, name, testErrors);
        end
    endtask

    initial begin
        rngState  = 32'd83;
        reset     = 1'b1;
        passCount = 0;
        failCount = 0;
        storeIdx  = 0;
        curTest   = 0;
        foreach (rom[i])
            rom[i] = '0;
        runTest(0, "reset and memory clear");
        for (int round = 0; round < rounds; round++) begin
            runTest(1, "alu forwarding");
            runTest(2, "load-use stall");
            runTest(3, "branch and jal");
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures", curTest,
                 passCount, failCount, u_dut.u_pipeline.u_assert.failures);
        if (failCount == 0 && u_dut.u_pipeline.u_assert.failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog sized from the per-test budget
    initial begin
        #(numTests * testCycles * 10);
        $display("Timeout, test %0d never finished its stores", curTest);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== common/rvPkg.sv ====
package rvPkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================
    localparam int xlen     = 32;
    localparam int memWords = 64;
    localparam int addrBits = $clog2(memWords);  // Word index bits into data memory

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [xlen-1:0] wordT;    // Data, address or instruction
    typedef logic [4:0]      regAddrT; // Register index

    // ALU operation
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlT;

    // Immediate format
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcT;

    // Writeback source
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcT;

    // Execute operand source
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } forwardT;

endpackage

// ==== core/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic             flushE,
    input  logic             regWriteD, memWriteD, branchD, jumpD, aluSrcD,
    input  rvPkg::resultSrcT resultSrcD,
    input  rvPkg::aluCtrlT   aluCtrlD,
    input  rvPkg::wordT      rd1D, rd2D, immExtD, pcD, pcPlus4D,
    input  rvPkg::regAddrT   rs1D, rs2D, rdD,
    input  rvPkg::forwardT   forwardA, forwardB,
    input  rvPkg::wordT      aluResultM, resultW,
    output logic             regWriteE, memWriteE,
    output rvPkg::resultSrcT resultSrcE,
    output rvPkg::regAddrT   rs1E, rs2E, rdE,
    output rvPkg::wordT      aluResultE, writeDataE, pcPlus4E, pcTarget,
    output logic             pcSrc
);
    import rvPkg::*;

    logic    branchE;
    logic    jumpE;
    logic    aluSrcE;
    aluCtrlT aluCtrlE;
    wordT    rd1E;
    wordT    rd2E;
    wordT    immExtE;
    wordT    pcE;
    wordT    srcA;
    wordT    srcB;
    logic    zeroE;

    // ========================================================================
    // Decode/execute register
    // ========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            branchE    <= 1'b0;
            jumpE      <= 1'b0;
            aluSrcE    <= 1'b0;
            resultSrcE <= resAlu;
            aluCtrlE   <= aluAdd;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
        end else if (flushE) begin  // Bubble
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            branchE    <= 1'b0;
            jumpE      <= 1'b0;
            aluSrcE    <= 1'b0;
            resultSrcE <= resAlu;
            aluCtrlE   <= aluAdd;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            branchE    <= branchD;
            jumpE      <= jumpD;
            aluSrcE    <= aluSrcD;
            resultSrcE <= resultSrcD;
            aluCtrlE   <= aluCtrlD;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= rdD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        immExtE  <= immExtD;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
    end

    // ========================================================================
    // Operands, ALU and redirect
    // ========================================================================
    assign srcA = (forwardA == fwdMem) ? aluResultM :
                  (forwardA == fwdWb)  ? resultW    : rd1E;
    assign writeDataE = (forwardB == fwdMem) ? aluResultM :
                        (forwardB == fwdWb)  ? resultW    : rd2E;
    assign srcB = aluSrcE ? immExtE : writeDataE;

    always_comb begin
        case (aluCtrlE)
            aluSub:  aluResultE = srcA - srcB;
            aluAnd:  aluResultE = srcA & srcB;
            aluOr:   aluResultE = srcA | srcB;
            aluSlt:  aluResultE = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluResultE = srcA + srcB;
        endcase
    end

    assign zeroE    = (aluResultE == '0);
    assign pcTarget = pcE + immExtE;            // Same adder for beq and jal
    assign pcSrc    = (branchE & zeroE) | jumpE;

endmodule

// ==== core/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit (
    input  logic        clk,
    input  logic        reset,
    input  logic        stallF,
    input  logic        stallD,
    input  logic        flushD,
    input  logic        pcSrc,
    input  rvPkg::wordT pcTarget,
    input  rvPkg::wordT instr,
    output rvPkg::wordT pc,
    output rvPkg::wordT instrD,
    output rvPkg::wordT pcD,
    output rvPkg::wordT pcPlus4D
);
    import rvPkg::*;

    wordT pcPlus4;
    wordT pcNext;

    assign pcPlus4 = pc + xlen'(4);
    assign pcNext  = pcSrc ? pcTarget : pcPlus4; // Taken branch or jal wins

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= '0;
        else if (!stallF)
            pc <= pcNext;
    end

    // Fetch/decode register, all-zero word decodes as a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            instrD <= '0;
        else if (flushD)
            instrD <= '0;
        else if (!stallD)
            instrD <= instr;
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD      <= pc;
            pcPlus4D <= pcPlus4;
        end
    end

endmodule

// ==== core/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  rvPkg::regAddrT   rs1D,
    input  rvPkg::regAddrT   rs2D,
    input  rvPkg::regAddrT   rs1E,
    input  rvPkg::regAddrT   rs2E,
    input  rvPkg::regAddrT   rdE,
    input  rvPkg::regAddrT   rdM,
    input  rvPkg::regAddrT   rdW,
    input  logic             regWriteM,
    input  logic             regWriteW,
    input  logic             pcSrc,
    input  rvPkg::resultSrcT resultSrcE,
    output rvPkg::forwardT   forwardA,
    output rvPkg::forwardT   forwardB,
    output logic             stallF,
    output logic             stallD,
    output logic             flushD,
    output logic             flushE
);
    import rvPkg::*;

    logic loadUse;

    // Youngest producer wins and x0 is never forwarded
    function automatic forwardT fwdSel(input regAddrT rs);
        if (rs != '0 && regWriteM && rs == rdM)
            return fwdMem;
        else if (rs != '0 && regWriteW && rs == rdW)
            return fwdWb;
        else
            return fwdNone;
    endfunction

    always_comb begin
        forwardA = fwdSel(rs1E);
        forwardB = fwdSel(rs2E);
    end

    assign loadUse = (resultSrcE == resMem) && (rdE != '0)
                   && (rdE == rs1D || rdE == rs2D);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = pcSrc;            // Drop the two younger instructions
    assign flushE = loadUse | pcSrc;  // Bubble behind a load or a redirect

endmodule

// ==== core/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
    input  rvPkg::wordT      instrD,
    output logic             regWriteD,
    output logic             memWriteD,
    output logic             branchD,
    output logic             jumpD,
    output logic             aluSrcD,
    output rvPkg::resultSrcT resultSrcD,
    output rvPkg::aluCtrlT   aluCtrlD,
    output rvPkg::wordT      immExtD,
    output rvPkg::regAddrT   rs1D,
    output rvPkg::regAddrT   rs2D,
    output rvPkg::regAddrT   rdD
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       useFunct;   // ALU op comes from funct3
    immSrcT     immSrc;

    assign opcode   = instrD[6:0];
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD  = instrD[11:7];

    // ========================================================================
    // Main control
    // ========================================================================
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        aluSrcD    = 1'b0;
        useFunct   = 1'b0;
        resultSrcD = resAlu;
        immSrc     = immI;
        case (opcode)
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resMem;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrc    = immS;
            end
            opRType: begin
                regWriteD = 1'b1;
                useFunct  = 1'b1;
            end
            opIType: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                useFunct  = 1'b1;
            end
            opBranch: begin
                branchD = 1'b1;
                immSrc  = immB;
            end
            opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                immSrc     = immJ;
                resultSrcD = resPcPlus4;
            end
            default: ;              // Unknown opcode stays inactive
        endcase
    end

    // ALU control
    always_comb begin
        aluCtrlD = aluAdd;          // Address generation and jal
        if (branchD)
            aluCtrlD = aluSub;      // beq compares by subtraction
        else if (useFunct) begin
            case (funct3)
                3'b000:  aluCtrlD = (opcode == opRType && funct7b5) ? aluSub : aluAdd;
                3'b010:  aluCtrlD = aluSlt;
                3'b110:  aluCtrlD = aluOr;
                3'b111:  aluCtrlD = aluAnd;
                default: aluCtrlD = aluAdd;
            endcase
        end
    end

    // Sign-extended immediate
    always_comb begin
        case (immSrc)
            immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                instrD[11:8], 1'b0};
            immJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                instrD[30:21], 1'b0};
            default: immExtD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

endmodule

// ==== core/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           reset,
    input  logic           regWriteW,
    input  rvPkg::regAddrT rs1D,
    input  rvPkg::regAddrT rs2D,
    input  rvPkg::regAddrT rdW,
    input  rvPkg::wordT    resultW,
    output rvPkg::wordT    rd1D,
    output rvPkg::wordT    rd2D
);
    import rvPkg::*;

    wordT regs [1:31];   // x0 has no storage

    // Same-cycle write is visible to the decode stage
    function automatic wordT readPort(input regAddrT addr);
        if (addr == '0)
            return '0;
        else if (regWriteW && addr == rdW)
            return resultW;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    always_comb begin
        rd1D = readPort(rs1D);
        rd2D = readPort(rs2D);
    end

endmodule

// ==== core/rvPipeline.sv ====
`timescale 1ns/100ps

module rvPipeline (
    input  logic        clk,
    input  logic        reset,
    input  rvPkg::wordT instr,
    input  rvPkg::wordT readData,
    output rvPkg::wordT pc,
    output rvPkg::wordT dataAdr,
    output rvPkg::wordT writeData,
    output logic        memWrite
);
    import rvPkg::*;

    // Fetch and decode
    wordT      instrD, pcD, pcPlus4D, immExtD, rd1D, rd2D;
    logic      regWriteD, memWriteD, branchD, jumpD, aluSrcD;
    resultSrcT resultSrcD;
    aluCtrlT   aluCtrlD;
    regAddrT   rs1D, rs2D, rdD;
    // Hazard controls
    logic      stallF, stallD, flushD, flushE;
    forwardT   forwardA, forwardB;
    // Execute
    logic      regWriteE, memWriteE, pcSrc;
    resultSrcT resultSrcE;
    regAddrT   rs1E, rs2E, rdE;
    wordT      aluResultE, writeDataE, pcPlus4E, pcTarget;
    // Memory and writeback
    logic      regWriteM, memWriteM, regWriteW;
    resultSrcT resultSrcM, resultSrcW;
    regAddrT   rdM, rdW;
    wordT      aluResultM, writeDataM, pcPlus4M;
    wordT      aluResultW, readDataW, pcPlus4W, resultW;

    fetchUnit u_fetch (.*);
    instrDecoder u_decoder (.*);
    regFile u_regFile (.*);
    hazardUnit u_hazard (.*);
    executeUnit u_execute (.*);

    // ========================================================================
    // Execute/memory and memory/writeback registers
    // ========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= resAlu;
            rdM        <= '0;
            regWriteW  <= 1'b0;
            resultSrcW <= resAlu;
            rdW        <= '0;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
            rdM        <= rdE;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
            rdW        <= rdM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        aluResultW <= aluResultM;
        readDataW  <= readData;
        pcPlus4W   <= pcPlus4M;
    end

    always_comb begin
        case (resultSrcW)
            resMem:     resultW = readDataW;
            resPcPlus4: resultW = pcPlus4W;   // jal link value
            default:    resultW = aluResultW;
        endcase
    end

    assign dataAdr   = aluResultM;
    assign writeData = writeDataM;
    assign memWrite  = memWriteM;   // One-cycle strobe per store

endmodule

// ==== logic/dataMemory.sv ====
`timescale 1ns/100ps

module dataMemory (
    input  logic        clk,
    input  logic        memWrite,
    input  rvPkg::wordT dataAdr,
    input  rvPkg::wordT writeData,
    output rvPkg::wordT readData
);
    import rvPkg::*;

    wordT                mem [memWords];
    logic [addrBits-1:0] wordAdr;

    assign wordAdr  = dataAdr[addrBits+1:2];  // Byte offset ignored
    assign readData = mem[wordAdr];

    always_ff @(posedge clk) begin
        if (memWrite)
            mem[wordAdr] <= writeData;
    end

endmodule

// ==== logic/rvSystem.sv ====
`timescale 1ns/100ps

module rvSystem (
    input  logic        clk,
    input  logic        reset,
    input  rvPkg::wordT instr,
    output rvPkg::wordT pc,
    output rvPkg::wordT dataAdr,
    output rvPkg::wordT writeData,
    output logic        memWrite
);
    import rvPkg::*;

    wordT readData;

    // Core with external instruction fetch port
    rvPipeline u_pipeline (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAdr   (dataAdr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    dataMemory u_dataMemory (
        .clk       (clk),
        .memWrite  (memWrite),
        .dataAdr   (dataAdr),
        .writeData (writeData),
        .readData  (readData)
    );

endmodule

// ==== project.f ====
+incdir+bench
common/rvPkg.sv
core/fetchUnit.sv
core/instrDecoder.sv
core/regFile.sv
core/hazardUnit.sv
core/executeUnit.sv
core/rvPipeline.sv
logic/dataMemory.sv
logic/rvSystem.sv
bench/rvPipeline_assert.sv
bench/rvSystemTb.sv
